// ==== rtl/proj_pkg.sv ====
package proj_pkg;

  // projector control states
  typedef enum logic [1:0] {
    IDLE    = 2'd0,  // waiting for a vertex
    COMPUTE = 2'd1,  // dot products and division in flight
    HOLD    = 2'd2   // visible result parked until downstream ready
  } proj_state_t;

  // divider sequencing
  typedef enum logic [1:0] {
    D_IDLE = 2'd0,
    D_RUN  = 2'd1,  // shift-subtract steps
    D_DONE = 2'd2   // done strobe, one cycle only
  } div_state_t;

  // default widths, shared by top level and testbench
  localparam int DEF_P_WIDTH     = 16;  // point coord, signed int
  localparam int DEF_C_WIDTH     = 18;  // camera coord, signed int
  localparam int DEF_V_WIDTH     = 16;  // basis component, signed fixed point
  localparam int DEF_FRAC_BITS   = 14;  // fraction bits of u/v/n
  localparam int DEF_FOCAL_SHIFT = 8;   // offset scale, power of two

  // viewport geometry
  localparam int DEF_HALF_W      = 320;
  localparam int DEF_HALF_H      = 240;
  localparam int DEF_POS_WIDTH   = 10;  // unsigned pixel position

endpackage

// ==== rtl/div_if.sv ====
`timescale 1ns/10ps

// one divider channel, projector drives master side
interface div_if #(
  parameter int DIVIDEND_W = 45,
  parameter int QUOT_W     = 12
);
  logic                  start;     // single-cycle kick
  logic [DIVIDEND_W-1:0] dividend;  // two's complement
  logic [DIVIDEND_W-1:0] divisor;   // sign extended to dividend width
  logic                  done;      // single-cycle, result valid here
  logic                  ok;        // divisor > 0 and quotient fit
  logic [QUOT_W-1:0]     quotient;  // signed, truncated toward zero

  modport master (
    output start, dividend, divisor,
    input  done, ok, quotient
  );

  modport slave (
    input  start, dividend, divisor,
    output done, ok, quotient
  );

endinterface

// ==== rtl/fixed_point_fast_dot.sv ====
`timescale 1ns/10ps

// a . b over three terms, result 2 cycles after inputs
// a is integer, b carries the fraction bits, so d has the same fraction
module fixed_point_fast_dot import proj_pkg::*; #(
  parameter int A_WIDTH = DEF_C_WIDTH + 1,  // camera-relative coord
  parameter int B_WIDTH = DEF_V_WIDTH       // basis component
) (
  input  logic                                 clk_in,
  input  logic                                 rst_in,
  input  logic        [2:0][A_WIDTH-1:0]       a,
  input  logic        [2:0][B_WIDTH-1:0]       b,
  output logic signed [A_WIDTH+B_WIDTH+1:0]    d
);

  localparam int PROD_W = A_WIDTH + B_WIDTH;

  logic signed [PROD_W-1:0] prod [3];  // stage one

  // stage one: three signed products
  // elements of a packed array are unsigned, so cast each one
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      prod[0] <= '0;
      prod[1] <= '0;
      prod[2] <= '0;
    end else begin
      prod[0] <= $signed(a[0]) * $signed(b[0]);  // x term
      prod[1] <= $signed(a[1]) * $signed(b[1]);  // y term
      prod[2] <= $signed(a[2]) * $signed(b[2]);  // z term
    end
  end

  // stage two: full-width sum, two guard bits
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      d <= '0;
    end else begin
      d <= prod[0] + prod[1] + prod[2];  // sign extends to d width
    end
  end

endmodule

// ==== rtl/fixed_point_div.sv ====
`timescale 1ns/10ps

// restoring signed divider, done exactly QUOT_W+1 cycles after start
// quotient truncates toward zero
module fixed_point_div import proj_pkg::*; #(
  parameter int DIVIDEND_W = 45,
  parameter int QUOT_W     = 12
) (
  input logic  clk_in,
  input logic  rst_in,
  div_if.slave bus
);

  localparam int CNT_W = (QUOT_W > 2) ? $clog2(QUOT_W) : 1;

  div_state_t            state;
  logic [CNT_W-1:0]      cnt;       // step index
  logic                  last_step;

  logic [DIVIDEND_W-1:0] a_mag;     // |dividend|, combinational
  logic [DIVIDEND_W-1:0] rem;       // partial remainder
  logic [DIVIDEND_W-1:0] b_mag;     // divisor, positive when ok
  logic [QUOT_W-1:0]     low;       // dividend bits still to shift in
  logic [QUOT_W-1:0]     q;         // quotient magnitude so far
  logic                  neg;       // result sign
  logic                  div_bad;   // divisor zero or negative
  logic                  ovf;       // quotient would not fit

  logic [DIVIDEND_W:0]   rem_sh;
  logic [DIVIDEND_W:0]   diff;
  logic                  q_bit;
  logic [QUOT_W-1:0]     q_next;

  logic [QUOT_W-1:0]     quot_r;
  logic                  ok_r;

  // magnitude of the most negative value still fits unsigned
  assign a_mag = bus.dividend[DIVIDEND_W-1] ? -bus.dividend : bus.dividend;

  // one restoring step
  assign rem_sh = {rem, low[QUOT_W-1]};
  assign diff   = rem_sh - {1'b0, b_mag};
  assign q_bit  = ~diff[DIVIDEND_W];  // no borrow -> subtract
  assign q_next = {q[QUOT_W-2:0], q_bit};

  assign last_step = (state == D_RUN) && (cnt == CNT_W'(QUOT_W - 1));

  // control
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= D_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        D_IDLE: begin
          if (bus.start) begin
            state <= D_RUN;
            cnt   <= '0;
          end
        end
        D_RUN: begin
          cnt <= cnt + 1'b1;
          if (last_step) state <= D_DONE;
        end
        default: state <= D_IDLE;  // D_DONE, single cycle
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk_in) begin
    if (state == D_IDLE && bus.start) begin
      rem     <= a_mag >> QUOT_W;          // high part, below divisor if no ovf
      low     <= a_mag[QUOT_W-1:0];
      b_mag   <= bus.divisor;
      neg     <= bus.dividend[DIVIDEND_W-1];
      div_bad <= bus.divisor[DIVIDEND_W-1] || (bus.divisor == '0);
      ovf     <= (a_mag >> (QUOT_W - 1)) >= bus.divisor;  // needs > QUOT_W-1 bits
      q       <= '0;
    end else if (state == D_RUN) begin
      rem <= q_bit ? diff[DIVIDEND_W-1:0] : rem_sh[DIVIDEND_W-1:0];
      low <= low << 1;
      q   <= q_next;
      if (last_step) begin
        quot_r <= neg ? -q_next : q_next;  // restore sign
        ok_r   <= !(div_bad || ovf);
      end
    end
  end

  assign bus.done     = (state == D_DONE);
  assign bus.ok       = ok_r;
  assign bus.quotient = quot_r;

  // done strobes only QUOT_W+1 cycles after an accepted start, one cycle long
  a_done_pulse : assert property (@(posedge clk_in) disable iff (rst_in)
    bus.done |-> $past(bus.start && state == D_IDLE, QUOT_W + 1));

  // master must not restart a busy divider
  a_no_start_busy : assert property (@(posedge clk_in) disable iff (rst_in)
    (state == D_RUN) |-> !bus.start);

endmodule

// ==== rtl/project_vertex_to_viewport.sv ====
`timescale 1ns/10ps

// project one point into viewport pixels, or flag it undrawable
module project_vertex_to_viewport import proj_pkg::*; #(
  parameter int P_WIDTH     = DEF_P_WIDTH,
  parameter int C_WIDTH     = DEF_C_WIDTH,
  parameter int V_WIDTH     = DEF_V_WIDTH,
  parameter int FRAC_BITS   = DEF_FRAC_BITS,
  parameter int FOCAL_SHIFT = DEF_FOCAL_SHIFT,
  parameter int HALF_W      = DEF_HALF_W,
  parameter int HALF_H      = DEF_HALF_H,
  parameter int POS_WIDTH   = DEF_POS_WIDTH,
  parameter int QUOT_W      = 12
) (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          valid_in,
  input  logic                          ready_in,
  input  logic signed [2:0][P_WIDTH-1:0] P,  // [z, y, x]
  input  logic signed [2:0][C_WIDTH-1:0] C,
  input  logic signed [2:0][V_WIDTH-1:0] u,  // screen right
  input  logic signed [2:0][V_WIDTH-1:0] v,  // screen up
  input  logic signed [2:0][V_WIDTH-1:0] n,  // view direction
  output logic                          valid_out,
  output logic                          ready_out,
  output logic                          short_circuit,
  output logic [POS_WIDTH-1:0]          viewport_x_position,
  output logic [POS_WIDTH-1:0]          viewport_y_position,
  output logic signed [C_WIDTH:0]       z_depth
);

  localparam int PC_W  = C_WIDTH + 1;             // P - C never overflows
  localparam int DOT_W = PC_W + V_WIDTH + 2;      // full dot width
  localparam int DIV_W = DOT_W + FOCAL_SHIFT;     // scaled dividend

  proj_state_t                  state;
  logic [1:0]                   start_sr;  // acceptance delayed to dot output
  logic                         accept;
  logic                         div_done;
  logic                         visible;

  logic signed [2:0][PC_W-1:0]  p_cam;     // camera-relative point
  logic signed [DOT_W-1:0]      u_dot;
  logic signed [DOT_W-1:0]      v_dot;
  logic signed [DOT_W-1:0]      n_dot;     // depth before shift
  logic signed [QUOT_W-1:0]     x_q;
  logic signed [QUOT_W-1:0]     y_q;

  div_if #(.DIVIDEND_W(DIV_W), .QUOT_W(QUOT_W)) x_div ();
  div_if #(.DIVIDEND_W(DIV_W), .QUOT_W(QUOT_W)) y_div ();

  // camera subtraction, elementwise
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      p_cam[i] = $signed(P[i]) - $signed(C[i]);  // sign extends to PC_W
    end
  end

  fixed_point_fast_dot #(.A_WIDTH(PC_W), .B_WIDTH(V_WIDTH)) dp_u (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .a      (p_cam),
    .b      (u),
    .d      (u_dot)
  );

  fixed_point_fast_dot #(.A_WIDTH(PC_W), .B_WIDTH(V_WIDTH)) dp_v (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .a      (p_cam),
    .b      (v),
    .d      (v_dot)
  );

  fixed_point_fast_dot #(.A_WIDTH(PC_W), .B_WIDTH(V_WIDTH)) dp_n (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .a      (p_cam),
    .b      (n),
    .d      (n_dot)
  );

  // both dividers kicked together, same divisor
  assign x_div.start    = start_sr[1];
  assign y_div.start    = start_sr[1];
  assign x_div.dividend = {u_dot, {FOCAL_SHIFT{1'b0}}};  // u.p << FOCAL_SHIFT
  assign y_div.dividend = {v_dot, {FOCAL_SHIFT{1'b0}}};
  assign x_div.divisor  = {{FOCAL_SHIFT{n_dot[DOT_W-1]}}, n_dot};
  assign y_div.divisor  = {{FOCAL_SHIFT{n_dot[DOT_W-1]}}, n_dot};

  fixed_point_div #(.DIVIDEND_W(DIV_W), .QUOT_W(QUOT_W)) x_renormalization (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .bus    (x_div.slave)
  );

  fixed_point_div #(.DIVIDEND_W(DIV_W), .QUOT_W(QUOT_W)) y_renormalization (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .bus    (y_div.slave)
  );

  assign accept   = valid_in && ready_out && (state == IDLE);
  assign div_done = x_div.done && y_div.done;  // lockstep
  assign x_q      = $signed(x_div.quotient);
  assign y_q      = $signed(y_div.quotient);

  // behind camera shows up as !ok, bounds are strict
  assign visible = x_div.ok && y_div.ok &&
                   (x_q > -HALF_W) && (x_q < HALF_W) &&
                   (y_q > -HALF_H) && (y_q < HALF_H);

  // handshake FSM
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= IDLE;
      start_sr      <= '0;
      ready_out     <= 1'b1;
      valid_out     <= 1'b0;
      short_circuit <= 1'b0;
    end else begin
      start_sr      <= {start_sr[0], accept};
      valid_out     <= 1'b0;  // pulses by default
      short_circuit <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            ready_out <= 1'b0;  // one vertex at a time
            state     <= COMPUTE;
          end else begin
            ready_out <= 1'b1;  // reopens after a result pulse
          end
        end
        COMPUTE: begin
          if (div_done) begin
            if (visible) begin
              state <= HOLD;
            end else begin
              short_circuit <= 1'b1;
              state         <= IDLE;
            end
          end
        end
        HOLD: begin
          if (ready_in) begin  // wait out back-pressure
            valid_out <= 1'b1;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // result capture, held until the next visible vertex
  always_ff @(posedge clk_in) begin
    if (state == COMPUTE && div_done && visible) begin
      viewport_x_position <= POS_WIDTH'(x_q + HALF_W);  // shift to [0, 2*HALF_W)
      viewport_y_position <= POS_WIDTH'(y_q + HALF_H);
      z_depth             <= (C_WIDTH + 1)'(n_dot >>> FRAC_BITS);  // drop fraction
    end
  end

  a_one_result : assert property (@(posedge clk_in) disable iff (rst_in)
    !(valid_out && short_circuit));

endmodule

// ==== rtl/vertex_projector_top.sv ====
`timescale 1ns/10ps

// top level, plain ports, no logic of its own
module vertex_projector_top import proj_pkg::*; #(
  parameter int P_WIDTH     = DEF_P_WIDTH,
  parameter int C_WIDTH     = DEF_C_WIDTH,
  parameter int V_WIDTH     = DEF_V_WIDTH,
  parameter int FRAC_BITS   = DEF_FRAC_BITS,
  parameter int FOCAL_SHIFT = DEF_FOCAL_SHIFT,
  parameter int HALF_W      = DEF_HALF_W,
  parameter int HALF_H      = DEF_HALF_H,
  parameter int POS_WIDTH   = DEF_POS_WIDTH,
  parameter int QUOT_W      = 12  // signed quotient, covers +-HALF_W
) (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic                          valid_in,
  input  logic                          ready_in,
  input  logic signed [2:0][P_WIDTH-1:0] P,
  input  logic signed [2:0][C_WIDTH-1:0] C,
  input  logic signed [2:0][V_WIDTH-1:0] u,
  input  logic signed [2:0][V_WIDTH-1:0] v,
  input  logic signed [2:0][V_WIDTH-1:0] n,
  output logic                          valid_out,
  output logic                          ready_out,
  output logic                          short_circuit,
  output logic [POS_WIDTH-1:0]          viewport_x_position,
  output logic [POS_WIDTH-1:0]          viewport_y_position,
  output logic signed [C_WIDTH:0]       z_depth
);

  project_vertex_to_viewport #(
    .P_WIDTH     (P_WIDTH),
    .C_WIDTH     (C_WIDTH),
    .V_WIDTH     (V_WIDTH),
    .FRAC_BITS   (FRAC_BITS),
    .FOCAL_SHIFT (FOCAL_SHIFT),
    .HALF_W      (HALF_W),
    .HALF_H      (HALF_H),
    .POS_WIDTH   (POS_WIDTH),
    .QUOT_W      (QUOT_W)
  ) projector (
    .clk_in              (clk_in),
    .rst_in              (rst_in),
    .valid_in            (valid_in),
    .ready_in            (ready_in),
    .P                   (P),
    .C                   (C),
    .u                   (u),
    .v                   (v),
    .n                   (n),
    .valid_out           (valid_out),
    .ready_out           (ready_out),
    .short_circuit       (short_circuit),
    .viewport_x_position (viewport_x_position),
    .viewport_y_position (viewport_y_position),
    .z_depth             (z_depth)
  );

endmodule

// ==== verification/tb_vertex_projector.sv ====
`timescale 1ns/10ps

// vertex projector testbench, vectors and expected results come from a text file
module tb_vertex_projector import proj_pkg::*; ();

  localparam int    POS_W    = DEF_POS_WIDTH;
  localparam int    DEPTH_W  = DEF_C_WIDTH + 1;
  localparam int    WAIT_MAX = 200;  // cycles allowed per wait loop
  localparam string VEC_FILE = "verification/vertex_input.txt";

  // columns after the 15 vector components
  localparam int COL_VIS = 15;
  localparam int COL_X   = 16;
  localparam int COL_Y   = 17;
  localparam int COL_Z   = 18;

  logic                                clk_in;
  logic                                rst_in;
  logic                                valid_in;
  logic                                ready_in;
  logic signed [2:0][DEF_P_WIDTH-1:0]  pt;     // [z, y, x]
  logic signed [2:0][DEF_C_WIDTH-1:0]  cam;
  logic signed [2:0][DEF_V_WIDTH-1:0]  u_vec;
  logic signed [2:0][DEF_V_WIDTH-1:0]  v_vec;
  logic signed [2:0][DEF_V_WIDTH-1:0]  n_vec;
  logic                                valid_out;
  logic                                ready_out;
  logic                                short_circuit;
  logic [POS_W-1:0]                    x_pos;
  logic [POS_W-1:0]                    y_pos;
  logic signed [DEPTH_W-1:0]           depth;

  integer seed;
  int     fld [19];  // one parsed vector line
  string  label;
  int     pass_cnt;
  int     fail_cnt;
  bit     aborted;   // a wait ran out, stop reading vectors

  vertex_projector_top DUT (
    .clk_in              (clk_in),
    .rst_in              (rst_in),
    .valid_in            (valid_in),
    .ready_in            (ready_in),
    .P                   (pt),
    .C                   (cam),
    .u                   (u_vec),
    .v                   (v_vec),
    .n                   (n_vec),
    .valid_out           (valid_out),
    .ready_out           (ready_out),
    .short_circuit       (short_circuit),
    .viewport_x_position (x_pos),
    .viewport_y_position (y_pos),
    .z_depth             (depth)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;  // 40 ns period
  end

  task automatic flag_mismatch(input string what, input int got, input int exp);
    $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  // outputs right after reset, nothing driven yet
  task automatic check_reset_state();
    bit ok;
    ok = 1'b1;
    @(negedge clk_in);
    if (valid_out !== 1'b0) begin
      flag_mismatch("valid_out after reset", valid_out, 0);
      ok = 1'b0;
    end
    if (short_circuit !== 1'b0) begin
      flag_mismatch("short_circuit after reset", short_circuit, 0);
      ok = 1'b0;
    end
    if (ready_out !== 1'b1) begin
      flag_mismatch("ready_out after reset", ready_out, 1);
      ok = 1'b0;
    end
    if (ok) pass_cnt++;
    else    fail_cnt++;
    $display("test 0 reset_state: %s", ok ? "ok" : "failed");
  endtask

  // one vertex: send, stall downstream, stray strobe, count result pulses
  task automatic run_vector(input int test_no);
    int cyc;
    int stall;
    int wait_cnt;
    int n_valid;
    int n_short;
    bit ok;
    bit finished;
    ok       = 1'b1;
    n_valid  = 0;
    n_short  = 0;
    finished = 1'b0;
    stall    = {$random(seed)} % 24;  // sometimes past the HOLD entry

    wait_cnt = 0;
    while (ready_out !== 1'b1 && wait_cnt < WAIT_MAX) begin
      @(negedge clk_in);
      wait_cnt++;
    end
    if (ready_out !== 1'b1) begin
      $display("ready_out never came high before test %0d (%s)", test_no, label);
      fail_cnt++;
      aborted = 1'b1;
      return;
    end

    @(posedge clk_in);
    valid_in <= 1'b1;
    ready_in <= 1'b0;
    for (int i = 0; i < 3; i++) begin
      pt[i]    <= fld[i][DEF_P_WIDTH-1:0];
      cam[i]   <= fld[3 + i][DEF_C_WIDTH-1:0];
      u_vec[i] <= fld[6 + i][DEF_V_WIDTH-1:0];
      v_vec[i] <= fld[9 + i][DEF_V_WIDTH-1:0];
      n_vec[i] <= fld[12 + i][DEF_V_WIDTH-1:0];
    end

    cyc = 0;
    while (!finished && cyc < WAIT_MAX) begin
      @(posedge clk_in);
      cyc++;
      valid_in <= (cyc == 4);      // second strobe while busy, must be ignored
      ready_in <= (cyc >= stall);
      @(negedge clk_in);
      if (valid_out === 1'b1) begin
        n_valid++;
        if (cyc <= stall) begin
          $display("Fail at %0t: valid_out while ready_in still low", $time);
          ok = 1'b0;
        end
        if (fld[COL_VIS] != 1) begin
          $display("Fail at %0t: valid_out for a vertex that should short-circuit", $time);
          ok = 1'b0;
        end else begin
          if (x_pos !== fld[COL_X][POS_W-1:0]) begin
            flag_mismatch("viewport_x_position", x_pos, fld[COL_X]);
            ok = 1'b0;
          end
          if (y_pos !== fld[COL_Y][POS_W-1:0]) begin
            flag_mismatch("viewport_y_position", y_pos, fld[COL_Y]);
            ok = 1'b0;
          end
          if (depth !== fld[COL_Z][DEPTH_W-1:0]) begin
            flag_mismatch("z_depth", depth, fld[COL_Z]);
            ok = 1'b0;
          end
        end
      end
      if (short_circuit === 1'b1) begin
        n_short++;
        if (fld[COL_VIS] != 0) begin
          $display("Fail at %0t: short_circuit for a visible vertex", $time);
          ok = 1'b0;
        end
      end
      if (ready_out === 1'b1) finished = 1'b1;  // reopened, transaction over
    end

    if (!finished) begin
      if (n_valid + n_short == 0) begin
        $display("neither valid_out nor short_circuit came for test %0d (%s)",
                 test_no, label);
      end else begin
        $display("ready_out never came back high after test %0d (%s)", test_no, label);
      end
      ok      = 1'b0;
      aborted = 1'b1;
    end else if (n_valid + n_short != 1) begin
      $display("Fail at %0t: %0d valid_out and %0d short_circuit pulses, expected one",
               $time, n_valid, n_short);
      ok = 1'b0;
    end
    if (ok) pass_cnt++;
    else    fail_cnt++;
    $display("test %0d %s: %s", test_no, label, ok ? "ok" : "failed");
  endtask

  initial begin
    int    fd;
    int    cnt;
    int    test_no;
    string line;
    seed     = 32'h5c12;
    pass_cnt = 0;
    fail_cnt = 0;
    aborted  = 1'b0;
    test_no  = 0;
    rst_in   = 1'b1;
    valid_in = 1'b0;
    ready_in = 1'b1;
    pt       = '0;
    cam      = '0;
    u_vec    = '0;
    v_vec    = '0;
    n_vec    = '0;

    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;
    check_reset_state();

    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VEC_FILE);
      fail_cnt++;
    end else begin
      while (!aborted && !$feof(fd)) begin
        cnt = $fgets(line, fd);
        if (cnt == 0 || line.len() < 2 || line[0] == "#") continue;  // blank or comment
        cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %s",
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                      fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
                      fld[14], fld[15], fld[16], fld[17], fld[18], label);
        if (cnt != 20) begin
          $display("malformed line in the vector file: %s", line);
          fail_cnt++;
          continue;
        end
        test_no++;
        run_vector(test_no);
      end
      $fclose(fd);
    end

    $display("pass count %0d, fail count %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt > 1) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verification/vertex_input.txt ====
# px py pz  cx cy cz  ux uy uz  vx vy vz  nx ny nz  visible exp_x exp_y exp_depth  label
# basis components have 14 fraction bits (16384 = 1.0), unused expected fields are 0
0 0 100 0 0 0 16384 0 0 0 16384 0 0 0 16384 1 320 240 100 center
50 -30 200 10 20 -56 16384 0 0 0 16384 0 0 0 16384 1 360 190 256 camera_offset
100 77 300 0 0 0 16384 0 0 0 16384 0 0 0 16384 1 405 305 300 truncate_positive
-100 -77 300 0 0 0 16384 0 0 0 16384 0 0 0 16384 1 235 175 300 truncate_negative
0 0 -50 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 behind_camera
10 10 0 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 zero_depth
5 5 10 0 0 20 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 camera_past_point
200 0 100 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 x_over_positive
-1000 0 1 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 x_over_negative_overflow
125 0 100 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 x_on_edge
0 100 100 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 y_over_positive
0 -100 100 0 0 0 16384 0 0 0 16384 0 0 0 16384 0 0 0 0 y_over_negative
319 -239 256 0 0 0 16384 0 0 0 16384 0 0 0 16384 1 639 1 256 inner_corner
30 20 101 0 0 0 16384 0 0 0 16384 0 0 0 8192 1 472 341 50 half_scale_depth
-40 30 -128 0 0 0 -16384 0 0 0 16384 0 0 0 -16384 1 400 300 128 looking_down_minus_z
1000 -1000 30000 0 0 -100000 16384 0 0 0 16384 0 0 0 16384 1 321 239 130000 far_camera

// ==== files.f ====
rtl/proj_pkg.sv
rtl/div_if.sv
rtl/fixed_point_fast_dot.sv
rtl/fixed_point_div.sv
rtl/project_vertex_to_viewport.sv
rtl/vertex_projector_top.sv
verification/tb_vertex_projector.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the vertex projector testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vertex_projector -f files.f -o tb_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
